/* files.f */
+incdir+include
rtl/core_pkg.sv
rtl/clint_timer.sv
rtl/bus_crossbar.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/core_top.sv
sim/core_checker.sv
sim/tb_core.sv

/* include/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// First instruction address after reset
`define CORE_RESET_PC 32'h0000_0000

// Core-local timer region of 64 KiB
`define CORE_CLINT_BASE 32'h0200_0000
`define CORE_CLINT_MTIME_LO 32'h0000_bff8
`define CORE_CLINT_MTIME_HI 32'h0000_bffc

// RV32E has x0..x15
`define CORE_NUM_REGS 16

`endif

/* rtl/bus_crossbar.sv */
`include "core_config.svh"

module bus_crossbar (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               fetch_ar_valid,
	output logic               fetch_ar_ready,
	input  core_pkg::ar_chan_t fetch_ar,
	output logic               fetch_r_valid,
	input  logic               fetch_r_ready,
	output core_pkg::r_chan_t  fetch_r,
	input  logic               lsu_ar_valid,
	output logic               lsu_ar_ready,
	input  core_pkg::ar_chan_t lsu_ar,
	output logic               lsu_r_valid,
	input  logic               lsu_r_ready,
	output core_pkg::r_chan_t  lsu_r,
	input  logic               lsu_aw_valid,
	output logic               lsu_aw_ready,
	input  core_pkg::aw_chan_t lsu_aw,
	input  logic               lsu_w_valid,
	output logic               lsu_w_ready,
	input  core_pkg::w_chan_t  lsu_w,
	output logic               lsu_b_valid,
	input  logic               lsu_b_ready,
	output core_pkg::resp_t    lsu_b_resp,
	output logic               ar_valid,
	input  logic               ar_ready,
	output core_pkg::ar_chan_t ar,
	input  logic               r_valid,
	output logic               r_ready,
	input  core_pkg::r_chan_t  r,
	output logic               aw_valid,
	input  logic               aw_ready,
	output core_pkg::aw_chan_t aw,
	output logic               w_valid,
	input  logic               w_ready,
	output core_pkg::w_chan_t  w,
	input  logic               b_valid,
	output logic               b_ready,
	input  core_pkg::resp_t    b_resp,
	output core_pkg::word_t    timer_addr,
	output logic               timer_req,
	input  core_pkg::word_t    timer_data
);
	import core_pkg::*;

	localparam word_t clint_base = `CORE_CLINT_BASE;

	bus_state_t st;
	ar_chan_t   sel_ar;
	r_chan_t    rd_chan;
	logic       any_ar, sel_lsu, hit_timer, ar_hs;
	logic       grant_lsu, to_timer, rd_valid, rd_ready;

	assign any_ar = lsu_ar_valid || fetch_ar_valid;
	assign sel_lsu = lsu_ar_valid; // Load/store wins over fetch
	assign sel_ar = sel_lsu ? lsu_ar : fetch_ar;
	assign hit_timer = sel_ar.addr[31:16] == clint_base[31:16];

	assign ar_valid = (st == bus_idle) && any_ar && !hit_timer;
	assign ar = sel_ar;
	assign timer_req = (st == bus_idle) && any_ar && hit_timer;
	assign timer_addr = sel_ar.addr;
	assign ar_hs = timer_req || (ar_valid && ar_ready); // Timer accepts at once
	assign lsu_ar_ready = (st == bus_idle) && sel_lsu && (hit_timer || ar_ready);
	assign fetch_ar_ready = (st == bus_idle) && !sel_lsu && (hit_timer || ar_ready);

	assign rd_chan = to_timer ? r_chan_t'{data: timer_data, resp: 2'b00} : r;
	assign rd_valid = (st == bus_data) && (to_timer || r_valid);
	assign rd_ready = grant_lsu ? lsu_r_ready : fetch_r_ready;
	assign lsu_r_valid = rd_valid && grant_lsu;
	assign fetch_r_valid = rd_valid && !grant_lsu;
	assign lsu_r = rd_chan;
	assign fetch_r = rd_chan;
	assign r_ready = (st == bus_data) && !to_timer && rd_ready;

	// Writes only come from load/store and always go out
	assign aw_valid = lsu_aw_valid;
	assign aw = lsu_aw;
	assign lsu_aw_ready = aw_ready;
	assign w_valid = lsu_w_valid;
	assign w = lsu_w;
	assign lsu_w_ready = w_ready;
	assign lsu_b_valid = b_valid;
	assign lsu_b_resp = b_resp;
	assign b_ready = lsu_b_ready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			st <= bus_idle;
			grant_lsu <= 1'b0;
			to_timer <= 1'b0;
		end else if (st == bus_idle) begin
			if (ar_hs) begin
				st <= bus_data;
				grant_lsu <= sel_lsu;
				to_timer <= hit_timer;
			end
		end else if (rd_valid && rd_ready) begin
			st <= bus_idle;
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n) !(ar_valid && timer_req));

endmodule

/* rtl/clint_timer.sv */
`include "core_config.svh"

module clint_timer (
	input  logic            clock,
	input  logic            rst_n,
	input  core_pkg::word_t timer_addr,
	input  logic            timer_req,
	output core_pkg::word_t timer_data
);

	logic [63:0] mtime;

	always_ff @(posedge clock) begin
		if (!rst_n)
			mtime <= 64'd0;
		else
			mtime <= mtime + 64'd1;
	end

	always_ff @(posedge clock) begin
		if (timer_req) begin
			case (timer_addr)
				`CORE_CLINT_BASE + `CORE_CLINT_MTIME_LO: timer_data <= mtime[31:0];
				`CORE_CLINT_BASE + `CORE_CLINT_MTIME_HI: timer_data <= mtime[63:32];
				default: timer_data <= 32'd0; // Unmapped offsets read as zero
			endcase
		end
	end

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
	} alu_op_t;

	typedef enum logic [2:0] {
		kind_alu, kind_load, kind_store, kind_branch, kind_jal, kind_jalr, kind_halt
	} instr_kind_t;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111
	} opcode_t;

	typedef enum logic [1:0] {bus_idle, bus_addr, bus_data, bus_resp} bus_state_t;

	typedef enum logic [2:0] {
		fetch_idle, fetch_req, fetch_wait, fetch_hand, fetch_wb
	} fetch_state_t;

	typedef struct packed {
		word_t addr;
	} ar_chan_t;

	typedef struct packed {
		word_t data;
		resp_t resp;
	} r_chan_t;

	typedef struct packed {
		word_t      addr;
		logic [2:0] size;
	} aw_chan_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
	} w_chan_t;

	typedef struct packed {
		instr_kind_t kind;
		alu_op_t     alu_op;
		reg_idx_t    rd;
		logic        wen;
		word_t       rs1_val;
		word_t       rs2_val;
		word_t       imm;
		word_t       pc;
		logic        use_imm;
		logic        branch_ne;
		logic        store_byte;
	} decoded_t;

	typedef struct packed {
		instr_kind_t kind;
		reg_idx_t    rd;
		logic        wen;
		word_t       result;
		word_t       store_data;
		logic        store_byte;
	} exec_t;

endpackage

/* rtl/core_top.sv */
module core_top (
	input  logic               clock,
	input  logic               rst_n,
	output logic               ar_valid,
	input  logic               ar_ready,
	output core_pkg::ar_chan_t ar,
	input  logic               r_valid,
	output logic               r_ready,
	input  core_pkg::r_chan_t  r,
	output logic               aw_valid,
	input  logic               aw_ready,
	output core_pkg::aw_chan_t aw,
	output logic               w_valid,
	input  logic               w_ready,
	output core_pkg::w_chan_t  w,
	input  logic               b_valid,
	output logic               b_ready,
	input  core_pkg::resp_t    b_resp,
	output logic               halted
);
	import core_pkg::*;

	logic     fetch_ar_valid, fetch_ar_ready, fetch_r_valid, fetch_r_ready;
	ar_chan_t fetch_ar;
	r_chan_t  fetch_r;
	logic     lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
	ar_chan_t lsu_ar;
	r_chan_t  lsu_r;
	logic     lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready;
	logic     lsu_b_valid, lsu_b_ready;
	aw_chan_t lsu_aw;
	w_chan_t  lsu_w;
	resp_t    lsu_b_resp;

	logic     fetch_valid, decode_ready, decode_valid, execute_ready;
	logic     exec_valid, lsu_ready;
	word_t    instr, pc, next_pc;
	decoded_t dec;
	exec_t    ex;
	logic     wb_valid, wb_en;
	reg_idx_t wb_rd;
	word_t    wb_data;

	word_t    timer_addr, timer_data;
	logic     timer_req;

	fetch_unit u_fetch (
		.clock(clock), .rst_n(rst_n),
		.wb_valid(wb_valid), .next_pc(next_pc), .halt(halted),
		.ar_valid(fetch_ar_valid), .ar_ready(fetch_ar_ready), .ar(fetch_ar),
		.r_valid(fetch_r_valid), .r_ready(fetch_r_ready), .r(fetch_r),
		.fetch_valid(fetch_valid), .decode_ready(decode_ready), .instr(instr), .pc(pc)
	);

	decode_unit u_decode (
		.clock(clock), .rst_n(rst_n),
		.fetch_valid(fetch_valid), .decode_ready(decode_ready), .instr(instr), .pc(pc),
		.decode_valid(decode_valid), .execute_ready(execute_ready), .dec(dec),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_en(wb_en), .wb_data(wb_data),
		.halt(halted)
	);

	execute_unit u_execute (
		.clock(clock), .rst_n(rst_n),
		.decode_valid(decode_valid), .execute_ready(execute_ready), .dec(dec),
		.exec_valid(exec_valid), .lsu_ready(lsu_ready), .ex(ex), .next_pc(next_pc)
	);

	load_store_unit u_lsu (
		.clock(clock), .rst_n(rst_n),
		.exec_valid(exec_valid), .lsu_ready(lsu_ready), .ex(ex),
		.ar_valid(lsu_ar_valid), .ar_ready(lsu_ar_ready), .ar(lsu_ar),
		.r_valid(lsu_r_valid), .r_ready(lsu_r_ready), .r(lsu_r),
		.aw_valid(lsu_aw_valid), .aw_ready(lsu_aw_ready), .aw(lsu_aw),
		.w_valid(lsu_w_valid), .w_ready(lsu_w_ready), .w(lsu_w),
		.b_valid(lsu_b_valid), .b_ready(lsu_b_ready), .b_resp(lsu_b_resp),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_en(wb_en), .wb_data(wb_data)
	);

	bus_crossbar u_xbar (
		.clock(clock), .rst_n(rst_n),
		.fetch_ar_valid(fetch_ar_valid), .fetch_ar_ready(fetch_ar_ready), .fetch_ar(fetch_ar),
		.fetch_r_valid(fetch_r_valid), .fetch_r_ready(fetch_r_ready), .fetch_r(fetch_r),
		.lsu_ar_valid(lsu_ar_valid), .lsu_ar_ready(lsu_ar_ready), .lsu_ar(lsu_ar),
		.lsu_r_valid(lsu_r_valid), .lsu_r_ready(lsu_r_ready), .lsu_r(lsu_r),
		.lsu_aw_valid(lsu_aw_valid), .lsu_aw_ready(lsu_aw_ready), .lsu_aw(lsu_aw),
		.lsu_w_valid(lsu_w_valid), .lsu_w_ready(lsu_w_ready), .lsu_w(lsu_w),
		.lsu_b_valid(lsu_b_valid), .lsu_b_ready(lsu_b_ready), .lsu_b_resp(lsu_b_resp),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
		.r_valid(r_valid), .r_ready(r_ready), .r(r),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
		.timer_addr(timer_addr), .timer_req(timer_req), .timer_data(timer_data)
	);

	clint_timer u_timer (
		.clock(clock), .rst_n(rst_n),
		.timer_addr(timer_addr), .timer_req(timer_req), .timer_data(timer_data)
	);

endmodule

/* rtl/decode_unit.sv */
`include "core_config.svh"

module decode_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               fetch_valid,
	output logic               decode_ready,
	input  core_pkg::word_t    instr,
	input  core_pkg::word_t    pc,
	output logic               decode_valid,
	input  logic               execute_ready,
	output core_pkg::decoded_t dec,
	input  logic               wb_valid,
	input  core_pkg::reg_idx_t wb_rd,
	input  logic               wb_en,
	input  core_pkg::word_t    wb_data,
	output logic               halt
);
	import core_pkg::*;

	word_t      regs [`CORE_NUM_REGS];
	decoded_t   dec_n;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	logic [2:0] funct3;
	logic       funct7_5;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

	assign rs1 = instr[18:15];
	assign rs2 = instr[23:20];
	assign funct3 = instr[14:12];
	assign funct7_5 = instr[30];
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign decode_ready = !decode_valid && !halt;

	always_comb begin
		dec_n = '0;
		dec_n.kind = kind_halt; // ebreak and anything unsupported
		dec_n.alu_op = alu_add;
		dec_n.rd = instr[10:7];
		dec_n.rs1_val = (rs1 == '0) ? '0 : regs[rs1];
		dec_n.rs2_val = (rs2 == '0) ? '0 : regs[rs2];
		dec_n.pc = pc;
		dec_n.use_imm = 1'b1;
		case (instr[6:0])
			op_lui: begin
				dec_n.kind = kind_alu;
				dec_n.alu_op = alu_pass_b;
				dec_n.wen = 1'b1;
				dec_n.imm = imm_u;
			end
			op_imm: begin
				if (funct3 == 3'b000) begin
					dec_n.kind = kind_alu;
					dec_n.wen = 1'b1;
					dec_n.imm = imm_i;
				end
			end
			op_reg: begin
				dec_n.kind = kind_alu;
				dec_n.wen = 1'b1;
				dec_n.use_imm = 1'b0;
				case ({funct7_5, funct3})
					4'b0000: dec_n.alu_op = alu_add;
					4'b1000: dec_n.alu_op = alu_sub;
					4'b0111: dec_n.alu_op = alu_and;
					4'b0110: dec_n.alu_op = alu_or;
					4'b0100: dec_n.alu_op = alu_xor;
					4'b0010: dec_n.alu_op = alu_slt;
					default: dec_n.kind = kind_halt;
				endcase
			end
			op_load: begin
				if (funct3 == 3'b010) begin
					dec_n.kind = kind_load;
					dec_n.wen = 1'b1;
					dec_n.imm = imm_i;
				end
			end
			op_store: begin
				if (funct3 == 3'b010 || funct3 == 3'b000) begin
					dec_n.kind = kind_store;
					dec_n.imm = imm_s;
					dec_n.store_byte = funct3 == 3'b000;
				end
			end
			op_branch: begin
				if (funct3[2:1] == 2'b00) begin
					dec_n.kind = kind_branch;
					dec_n.imm = imm_b;
					dec_n.use_imm = 1'b0;
					dec_n.branch_ne = funct3[0];
				end
			end
			op_jal: begin
				dec_n.kind = kind_jal;
				dec_n.wen = 1'b1;
				dec_n.imm = imm_j;
			end
			op_jalr: begin
				dec_n.kind = kind_jalr;
				dec_n.wen = 1'b1;
				dec_n.imm = imm_i;
			end
			default: dec_n.kind = kind_halt;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			decode_valid <= 1'b0;
			halt <= 1'b0;
		end else if (fetch_valid && decode_ready) begin
			if (dec_n.kind == kind_halt)
				halt <= 1'b1; // Sticky until reset
			else
				decode_valid <= 1'b1;
		end else if (decode_valid && execute_ready) begin
			decode_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid && decode_ready)
			dec <= dec_n;
		if (wb_valid && wb_en && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	assert property (@(posedge clock) disable iff (!rst_n) $rose(decode_valid) |-> !halt);

endmodule

/* rtl/execute_unit.sv */
module execute_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               decode_valid,
	output logic               execute_ready,
	input  core_pkg::decoded_t dec,
	output logic               exec_valid,
	input  logic               lsu_ready,
	output core_pkg::exec_t    ex,
	output core_pkg::word_t    next_pc
);
	import core_pkg::*;

	word_t op_b;
	word_t alu_res;
	word_t link_pc;
	word_t target;
	logic  taken;

	assign execute_ready = !exec_valid;
	assign op_b = dec.use_imm ? dec.imm : dec.rs2_val;
	assign link_pc = dec.pc + 32'd4;
	assign taken = (dec.rs1_val == dec.rs2_val) ^ dec.branch_ne;

	always_comb begin
		case (dec.alu_op)
			alu_add: alu_res = dec.rs1_val + op_b; // Also load/store address and jalr
			alu_sub: alu_res = dec.rs1_val - op_b;
			alu_and: alu_res = dec.rs1_val & op_b;
			alu_or:  alu_res = dec.rs1_val | op_b;
			alu_xor: alu_res = dec.rs1_val ^ op_b;
			alu_slt: alu_res = {31'b0, $signed(dec.rs1_val) < $signed(op_b)};
			default: alu_res = op_b;
		endcase
	end

	always_comb begin
		case (dec.kind)
			kind_jal:    target = dec.pc + dec.imm;
			kind_jalr:   target = alu_res & ~32'd1;
			kind_branch: target = taken ? dec.pc + dec.imm : link_pc;
			default:     target = link_pc;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			exec_valid <= 1'b0;
		else if (decode_valid && execute_ready)
			exec_valid <= 1'b1;
		else if (exec_valid && lsu_ready)
			exec_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (decode_valid && execute_ready) begin
			ex.kind <= dec.kind;
			ex.rd <= dec.rd;
			ex.wen <= dec.wen;
			ex.result <= (dec.kind == kind_jal || dec.kind == kind_jalr) ? link_pc : alu_res;
			ex.store_data <= dec.rs2_val;
			ex.store_byte <= dec.store_byte;
			next_pc <= target;
		end
	end

endmodule

/* rtl/fetch_unit.sv */
`include "core_config.svh"

module fetch_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               wb_valid,
	input  core_pkg::word_t    next_pc,
	input  logic               halt,
	output logic               ar_valid,
	input  logic               ar_ready,
	output core_pkg::ar_chan_t ar,
	input  logic               r_valid,
	output logic               r_ready,
	input  core_pkg::r_chan_t  r,
	output logic               fetch_valid,
	input  logic               decode_ready,
	output core_pkg::word_t    instr,
	output core_pkg::word_t    pc
);
	import core_pkg::*;

	fetch_state_t st;

	assign ar_valid = st == fetch_req;
	assign ar.addr = pc;
	assign r_ready = st == fetch_wait;
	assign fetch_valid = st == fetch_hand;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			st <= fetch_idle;
			pc <= `CORE_RESET_PC;
		end else begin
			case (st)
				fetch_idle: st <= fetch_req;
				fetch_req:  if (ar_ready) st <= fetch_wait;
				fetch_wait: if (r_valid) st <= fetch_hand;
				fetch_hand: if (decode_ready) st <= fetch_wb;
				fetch_wb: begin
					if (wb_valid && !halt) begin // A halted core never refetches
						pc <= next_pc;
						st <= fetch_req;
					end
				end
				default: st <= fetch_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (r_valid && r_ready)
			instr <= r.data;
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

/* rtl/load_store_unit.sv */
module load_store_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               exec_valid,
	output logic               lsu_ready,
	input  core_pkg::exec_t    ex,
	output logic               ar_valid,
	input  logic               ar_ready,
	output core_pkg::ar_chan_t ar,
	input  logic               r_valid,
	output logic               r_ready,
	input  core_pkg::r_chan_t  r,
	output logic               aw_valid,
	input  logic               aw_ready,
	output core_pkg::aw_chan_t aw,
	output logic               w_valid,
	input  logic               w_ready,
	output core_pkg::w_chan_t  w,
	input  logic               b_valid,
	output logic               b_ready,
	input  core_pkg::resp_t    b_resp,
	output logic               wb_valid,
	output core_pkg::reg_idx_t wb_rd,
	output logic               wb_en,
	output core_pkg::word_t    wb_data
);
	import core_pkg::*;

	bus_state_t st;
	exec_t      op;
	logic       is_load, is_store;
	logic       aw_done, w_done, aw_hs, w_hs;

	assign is_load = op.kind == kind_load;
	assign is_store = op.kind == kind_store;
	assign lsu_ready = st == bus_idle;

	assign ar_valid = (st == bus_addr) && is_load;
	assign ar.addr = op.result;
	assign r_ready = st == bus_data;

	assign aw_valid = (st == bus_addr) && is_store && !aw_done;
	assign w_valid = (st == bus_addr) && is_store && !w_done;
	assign aw.addr = op.result;
	assign aw.size = op.store_byte ? 3'd0 : 3'd2;
	assign w.data = op.store_byte ? {4{op.store_data[7:0]}} : op.store_data;
	assign w.strb = op.store_byte ? strb_t'(4'b0001 << op.result[1:0]) : 4'b1111;
	assign b_ready = st == bus_resp;
	assign aw_hs = aw_valid && aw_ready;
	assign w_hs = w_valid && w_ready;

	assign wb_rd = op.rd;
	assign wb_en = op.wen;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			st <= bus_idle;
			wb_valid <= 1'b0;
			aw_done <= 1'b0;
			w_done <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			case (st)
				bus_idle: begin
					if (exec_valid) begin
						aw_done <= 1'b0;
						w_done <= 1'b0;
						if (ex.kind == kind_load || ex.kind == kind_store)
							st <= bus_addr;
						else
							wb_valid <= 1'b1;
					end
				end
				bus_addr: begin
					if (is_load) begin
						if (ar_ready)
							st <= bus_data;
					end else begin
						if (aw_hs)
							aw_done <= 1'b1;
						if (w_hs)
							w_done <= 1'b1;
						if ((aw_done || aw_hs) && (w_done || w_hs))
							st <= bus_resp;
					end
				end
				bus_data: begin
					if (r_valid) begin
						wb_valid <= 1'b1;
						st <= bus_idle;
					end
				end
				default: begin
					if (b_valid) begin // Response code is not checked
						wb_valid <= 1'b1;
						st <= bus_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (exec_valid && lsu_ready) begin
			op <= ex;
			wb_data <= ex.result;
		end else if (r_valid && r_ready) begin
			wb_data <= r.data;
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n) $rose(aw_valid) == $rose(w_valid));

endmodule

/* sim/core_checker.sv */
`include "core_config.svh"

module core_checker (
	input logic               clock,
	input logic               rst_n,
	input logic               ar_valid,
	input core_pkg::ar_chan_t ar,
	input logic               aw_valid,
	input logic               aw_ready,
	input core_pkg::aw_chan_t aw,
	input logic               w_valid,
	input logic               w_ready,
	input core_pkg::w_chan_t  w,
	input logic               b_valid,
	input logic               b_ready,
	input logic               halted
);
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam word_t clint_base = `CORE_CLINT_BASE;

	word_t    q_addr[$];
	word_t    q_data[$];
	strb_t    q_strb[$];
	int       q_mode[$]; // 0 exact, 1 any data, 2 data above previous store
	int       errors = 0;
	int       test_errors = 0;
	int       tests_run = 0;
	int       tests_failed = 0;
	word_t    last_data;
	aw_chan_t got_aw;
	w_chan_t  got_w;
	logic     halted_seen = 1'b0;

	task automatic fail_line(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic compare_field(input string name, input word_t exp, input word_t got);
		if (exp !== got)
			fail_line($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic begin_test();
		q_addr.delete();
		q_data.delete();
		q_strb.delete();
		q_mode.delete();
		test_errors = 0;
		halted_seen = 1'b0;
	endtask

	task automatic expect_store(input word_t addr, input word_t data, input strb_t strb,
			input int mode);
		q_addr.push_back(addr);
		q_data.push_back(data);
		q_strb.push_back(strb);
		q_mode.push_back(mode);
	endtask

	task automatic check_store();
		word_t      exp_data;
		strb_t      exp_strb;
		logic [2:0] exp_size;
		int         mode;
		if (q_addr.size() == 0) begin
			fail_line($sformatf("Unexpected store to %h at %0t", got_aw.addr, $time));
		end else begin
			exp_data = q_data.pop_front();
			exp_strb = q_strb.pop_front();
			exp_size = (exp_strb == 4'hf) ? 3'd2 : 3'd0; // Word or single byte
			mode = q_mode.pop_front();
			compare_field("aw.addr", q_addr.pop_front(), got_aw.addr);
			compare_field("aw.size", word_t'(exp_size), word_t'(got_aw.size));
			compare_field("w.strb", word_t'(exp_strb), word_t'(got_w.strb));
			if (mode == 0)
				compare_field("w.data", exp_data, got_w.data);
			if (mode == 2 && got_w.data <= last_data)
				fail_line($sformatf("Timer value did not increase at %0t: %h then %h",
					$time, last_data, got_w.data));
		end
		last_data = got_w.data;
	endtask

	// Handshakes seen mid-cycle complete on the next rising edge
	always @(negedge clock) begin
		if (rst_n) begin
			if (aw_valid && aw_ready)
				got_aw = aw;
			if (w_valid && w_ready)
				got_w = w;
			if (b_valid && b_ready)
				check_store();
			if (ar_valid && ar.addr[31:16] == clint_base[31:16])
				fail_line($sformatf("Timer address %h went out on the external bus", ar.addr));
			if (halted_seen && !halted)
				fail_line("Halted dropped before reset");
			if (halted_seen && ar_valid)
				fail_line("Read request issued after halt");
			if (halted)
				halted_seen = 1'b1;
		end
	end

	task automatic end_test(input int num, input string name);
		if (q_addr.size() != 0)
			fail_line($sformatf("Missing %0d expected store(s), first to %h",
				q_addr.size(), q_addr[0]));
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %0d %s: %s (%0d errors)", num, name,
			test_errors == 0 ? "ok" : "FAILED", test_errors);
	endtask

	task automatic report_counts();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	endtask

endmodule

/* sim/tb_core.sv */
`include "core_config.svh"

module tb_core;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam int num_progs = 5;
	localparam int num_runs = 2 * num_progs; // Second pass uses random ready delays
	localparam int watchdog_ns = num_runs * (16 * 40 + 30) * 4;
	localparam strb_t lane_strb [4] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};

	logic clock = 1'b0;
	logic rst_n = 1'b0;
	logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
	logic w_valid, w_ready, b_valid, b_ready, halted;
	ar_chan_t ar;
	r_chan_t  r;
	aw_chan_t aw;
	w_chan_t  w;
	resp_t    b_resp;

	word_t mem [256];
	word_t prog [num_progs][16];
	int    plen [num_progs];
	word_t preset [num_progs][4];
	word_t exp_addr [num_progs][8];
	word_t exp_data [num_progs][8];
	strb_t exp_strb [num_progs][8];
	int    exp_mode [num_progs][8];
	int    exp_n [num_progs];
	string names [num_progs];
	int    random_delays = 0;
	int    cur_test = 0;

	logic  rd_busy, aw_got, w_got, ar_take, r_take, aw_take, w_take, b_take;
	word_t rd_addr, take_addr, wr_addr, take_waddr, wr_data, take_data;
	strb_t wr_strb, take_strb;
	int    ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;

	core_top DUT (
		.clock(clock), .rst_n(rst_n),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
		.r_valid(r_valid), .r_ready(r_ready), .r(r),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
		.halted(halted)
	);

	core_checker CHK (
		.clock(clock), .rst_n(rst_n), .ar_valid(ar_valid), .ar(ar),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready), .halted(halted)
	);

	always #2 clock = ~clock;

	function automatic word_t itype(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
			logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t rtype(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic word_t stype(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic word_t btype(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic word_t jtype(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	function automatic word_t utype(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, 7'h37};
	endfunction

	function automatic int draw_delay();
		return random_delays ? int'($urandom % 4) : 0;
	endfunction

	task automatic put(input int t, input word_t instr);
		prog[t][plen[t]] = instr;
		plen[t]++;
	endtask

	task automatic store(input int t, input word_t a, input word_t d, input strb_t s,
			input int mode);
		exp_addr[t][exp_n[t]] = a;
		exp_data[t][exp_n[t]] = d;
		exp_strb[t][exp_n[t]] = s;
		exp_mode[t][exp_n[t]] = mode;
		exp_n[t]++;
	endtask

	task automatic build_table();
		for (int t = 0; t < num_progs; t++) begin
			plen[t] = 0;
			exp_n[t] = 0;
			for (int i = 0; i < 16; i++)
				prog[t][i] = 32'h0010_0073; // ebreak
			for (int i = 0; i < 4; i++)
				preset[t][i] = 32'h0;
		end
		names[0] = "alu";
		put(0, utype(1, 20'h12345));
		put(0, itype(7'h13, 1, 3'b000, 1, 12'h678));
		put(0, itype(7'h13, 2, 3'b000, 0, 12'hffd));
		put(0, itype(7'h13, 3, 3'b000, 0, 12'h200));
		put(0, stype(3'b010, 3, 1, 12'h000));
		put(0, rtype(7'h00, 3'b000, 4, 1, 2));
		put(0, stype(3'b010, 3, 4, 12'h004));
		put(0, rtype(7'h20, 3'b000, 5, 1, 2));
		put(0, stype(3'b010, 3, 5, 12'h008));
		put(0, rtype(7'h00, 3'b111, 6, 1, 2));
		put(0, stype(3'b010, 3, 6, 12'h00c));
		put(0, rtype(7'h00, 3'b110, 7, 1, 2));
		put(0, stype(3'b010, 3, 7, 12'h010));
		store(0, 32'h200, 32'h1234_5678, 4'hf, 0);
		store(0, 32'h204, 32'h1234_5675, 4'hf, 0);
		store(0, 32'h208, 32'h1234_567b, 4'hf, 0);
		store(0, 32'h20c, 32'h1234_5678, 4'hf, 0);
		store(0, 32'h210, 32'hffff_fffd, 4'hf, 0);

		names[1] = "load";
		preset[1][0] = 32'h0000_00f0;
		preset[1][1] = 32'h0000_0f0f;
		put(1, itype(7'h13, 3, 3'b000, 0, 12'h100));
		put(1, itype(7'h03, 1, 3'b010, 3, 12'h000));
		put(1, itype(7'h03, 2, 3'b010, 3, 12'h004));
		put(1, rtype(7'h00, 3'b100, 4, 1, 2));
		put(1, stype(3'b010, 3, 4, 12'h100));
		put(1, rtype(7'h20, 3'b000, 5, 2, 1));
		put(1, stype(3'b010, 3, 5, 12'h104));
		put(1, rtype(7'h00, 3'b010, 6, 1, 2));
		put(1, stype(3'b010, 3, 6, 12'h108));
		put(1, itype(7'h13, 7, 3'b000, 0, 12'hfff));
		put(1, rtype(7'h00, 3'b010, 8, 1, 7));
		put(1, stype(3'b010, 3, 8, 12'h10c));
		store(1, 32'h200, 32'h0000_0fff, 4'hf, 0);
		store(1, 32'h204, 32'h0000_0e1f, 4'hf, 0);
		store(1, 32'h208, 32'h0000_0001, 4'hf, 0);
		store(1, 32'h20c, 32'h0000_0000, 4'hf, 0);

		names[2] = "byte store";
		put(2, itype(7'h13, 1, 3'b000, 0, 12'h200));
		put(2, itype(7'h13, 2, 3'b000, 0, 12'h05a));
		for (int i = 0; i < 4; i++) begin
			put(2, stype(3'b000, 1, 2, 12'(i)));
			put(2, itype(7'h13, 2, 3'b000, 2, 12'h001));
			store(2, 32'h200 + i, {4{8'h5a + 8'(i)}}, lane_strb[i], 0);
		end

		names[3] = "control flow";
		put(3, itype(7'h13, 1, 3'b000, 0, 12'h005));
		put(3, itype(7'h13, 2, 3'b000, 0, 12'h005));
		put(3, itype(7'h13, 3, 3'b000, 0, 12'h200));
		put(3, btype(3'b000, 1, 2, 13'd8)); // Taken beq skips the next store
		put(3, stype(3'b010, 3, 1, 12'h000));
		put(3, btype(3'b001, 1, 2, 13'd12)); // Taking it would reach the store at pc 32
		put(3, btype(3'b000, 1, 0, 13'd8));
		put(3, btype(3'b001, 1, 0, 13'd8));
		put(3, stype(3'b010, 3, 0, 12'h004));
		put(3, jtype(4, 21'd8));
		put(3, stype(3'b010, 3, 0, 12'h008));
		put(3, stype(3'b010, 3, 4, 12'h00c));
		put(3, itype(7'h67, 5, 3'b000, 4, 12'h010)); // Jumps to pc 56
		put(3, stype(3'b010, 3, 0, 12'h010));
		put(3, stype(3'b010, 3, 5, 12'h014));
		store(3, 32'h20c, 32'd40, 4'hf, 0);
		store(3, 32'h214, 32'd52, 4'hf, 0);

		names[4] = "timer";
		put(4, utype(1, 20'h0200c));
		put(4, itype(7'h03, 2, 3'b010, 1, 12'hff8)); // mtime low
		put(4, itype(7'h13, 3, 3'b000, 0, 12'h200));
		put(4, itype(7'h13, 4, 3'b000, 0, 12'h001));
		put(4, rtype(7'h00, 3'b000, 4, 4, 4));
		put(4, itype(7'h03, 5, 3'b010, 1, 12'hff8));
		put(4, stype(3'b010, 3, 2, 12'h000));
		put(4, stype(3'b010, 3, 5, 12'h004));
		store(4, 32'h200, 32'h0, 4'hf, 1);
		store(4, 32'h204, 32'h0, 4'hf, 2);
	endtask

	task automatic run_test(input int t, input int num);
		@(posedge clock);
		#1 rst_n = 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'h0;
		for (int i = 0; i < 16; i++)
			mem[(`CORE_RESET_PC >> 2) + i] = prog[t][i];
		for (int i = 0; i < 4; i++)
			mem[64 + i] = preset[t][i];
		CHK.begin_test();
		for (int i = 0; i < exp_n[t]; i++)
			CHK.expect_store(exp_addr[t][i], exp_data[t][i], exp_strb[t][i], exp_mode[t][i]);
		repeat (10) @(posedge clock);
		#1 rst_n = 1'b1;
		while (!halted)
			@(posedge clock);
		repeat (20) @(posedge clock); // Quiet bus expected after halt
		CHK.end_test(num, names[t]);
	endtask

	// Memory model outputs change 1 ns after the rising edge
	always @(posedge clock) begin
		#1;
		if (!rst_n) begin
			ar_ready = 1'b0;
			r_valid = 1'b0;
			aw_ready = 1'b0;
			w_ready = 1'b0;
			b_valid = 1'b0;
			{rd_busy, aw_got, w_got} = '0;
			{ar_take, r_take, aw_take, w_take, b_take} = '0;
			{ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} = '0;
		end else begin
			if (ar_take) begin
				ar_ready = 1'b0;
				rd_busy = 1'b1;
				rd_addr = take_addr;
				ar_cnt = draw_delay();
			end
			if (r_take) begin
				r_valid = 1'b0;
				rd_busy = 1'b0;
				r_cnt = draw_delay();
			end
			if (aw_take) begin
				aw_ready = 1'b0;
				aw_got = 1'b1;
				wr_addr = take_waddr;
				aw_cnt = draw_delay();
			end
			if (w_take) begin
				w_ready = 1'b0;
				w_got = 1'b1;
				wr_data = take_data;
				wr_strb = take_strb;
				w_cnt = draw_delay();
			end
			if (b_take) begin
				b_valid = 1'b0;
				b_cnt = draw_delay();
			end
			if (ar_valid && !ar_ready && !rd_busy) begin
				if (ar_cnt == 0)
					ar_ready = 1'b1;
				else
					ar_cnt--;
			end
			if (rd_busy && !r_valid) begin
				if (r_cnt == 0) begin
					r_valid = 1'b1;
					r = '{data: mem[rd_addr[9:2]], resp: 2'b00};
				end else begin
					r_cnt--;
				end
			end
			if (aw_valid && !aw_ready && !aw_got) begin
				if (aw_cnt == 0)
					aw_ready = 1'b1;
				else
					aw_cnt--;
			end
			if (w_valid && !w_ready && !w_got) begin
				if (w_cnt == 0)
					w_ready = 1'b1;
				else
					w_cnt--;
			end
			if (aw_got && w_got && !b_valid) begin
				if (b_cnt == 0) begin
					for (int i = 0; i < 4; i++)
						if (wr_strb[i])
							mem[wr_addr[9:2]][8*i +: 8] = wr_data[8*i +: 8];
					b_valid = 1'b1;
					b_resp = 2'b00;
					aw_got = 1'b0;
					w_got = 1'b0;
				end else begin
					b_cnt--;
				end
			end
			// DUT outputs hold until the next edge, so these handshakes happen there
			ar_take = ar_valid && ar_ready;
			take_addr = ar.addr;
			r_take = r_valid && r_ready;
			aw_take = aw_valid && aw_ready;
			take_waddr = aw.addr;
			w_take = w_valid && w_ready;
			take_data = w.data;
			take_strb = w.strb;
			b_take = b_valid && b_ready;
		end
	end

	initial begin
		void'($urandom(33));
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		b_resp = 2'b00;
		build_table();
		for (int pass = 0; pass < 2; pass++) begin
			random_delays = pass;
			for (int t = 0; t < num_progs; t++) begin
				cur_test = pass * num_progs + t;
				run_test(t, cur_test);
			end
		end
		CHK.report_counts();
		if (CHK.errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: test %0d never halted", cur_test);
		$display("Testbench failed");
		$finish;
	end

endmodule
